//--- common/softmax_pkg.sv
package softmax_pkg;

  // Score words are signed Q8.8
  localparam int DATA_WIDTH = 16;

  // Words carried per input beat
  localparam int LANES = 4;

  // Exponential output is unsigned Q1.15 with 1.0 at 0x8000
  localparam int EXP_WIDTH = 16;

  // Accumulator width
  // 64 words of 0x8000 at most need 22 bits
  localparam int SUM_WIDTH = 24;

  // Most negative Q8.8 word
  // Subtraction saturates here
  localparam logic [DATA_WIDTH-1:0] SAT_MIN = 16'h8000;

  // Controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0, // Waiting for first beat
    LOAD  = 2'd1, // Storing beats, tracking max
    RUN   = 2'd2, // Reading buffer into exp pipe
    FLUSH = 2'd3  // Draining pipe until done
  } ctrl_state_t;

endpackage

//--- hdl/mode1_max.sv
`timescale 1ns/1ps

module mode1_max (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               load_en,
  input  logic                               first_beat,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane0,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane1,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane2,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane3,
  output logic [softmax_pkg::DATA_WIDTH-1:0] max_val
);

  logic signed [softmax_pkg::DATA_WIDTH-1:0] lane [softmax_pkg::LANES];
  logic signed [softmax_pkg::DATA_WIDTH-1:0] max01;
  logic signed [softmax_pkg::DATA_WIDTH-1:0] max23;
  logic signed [softmax_pkg::DATA_WIDTH-1:0] beat_max;
  logic signed [softmax_pkg::DATA_WIDTH-1:0] max_q;

  // Signed view of the lanes
  assign lane[0] = in_lane0;
  assign lane[1] = in_lane1;
  assign lane[2] = in_lane2;
  assign lane[3] = in_lane3;

  // Two level comparison tree
  assign max01    = (lane[0] > lane[1]) ? lane[0] : lane[1];
  assign max23    = (lane[2] > lane[3]) ? lane[2] : lane[3];
  assign beat_max = (max01 > max23) ? max01 : max23;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      max_q <= '0;
    end else if (load_en) begin
      if (first_beat) begin
        max_q <= beat_max; // New vector, drop old max
      end else if (beat_max > max_q) begin
        max_q <= beat_max;
      end
    end
  end

  // Held through RUN since load_en stays low
  assign max_val = max_q;

endmodule

//--- hdl/mode2_sub.sv
`timescale 1ns/1ps

module fixed_point_sub (
  input  logic [softmax_pkg::DATA_WIDTH-1:0] a,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] b,
  output logic [softmax_pkg::DATA_WIDTH-1:0] result
);

  localparam int DW = softmax_pkg::DATA_WIDTH;

  logic signed [DW:0] diff; // One guard bit

  // Sign extend both operands before subtracting
  assign diff = $signed({a[DW-1], a}) - $signed({b[DW-1], b});

  always_comb begin
    if (diff[DW] != diff[DW-1]) begin
      // Out of Q8.8 range, clamp by sign
      result = diff[DW] ? softmax_pkg::SAT_MIN : ~softmax_pkg::SAT_MIN;
    end else begin
      result = diff[DW-1:0];
    end
  end

endmodule

module mode2_sub (
  input  logic [softmax_pkg::DATA_WIDTH-1:0] a_inp0,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] a_inp1,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] a_inp2,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] a_inp3,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] b_inp,   // Vector max
  output logic [softmax_pkg::DATA_WIDTH-1:0] outp0,
  output logic [softmax_pkg::DATA_WIDTH-1:0] outp1,
  output logic [softmax_pkg::DATA_WIDTH-1:0] outp2,
  output logic [softmax_pkg::DATA_WIDTH-1:0] outp3
);

  logic [softmax_pkg::DATA_WIDTH-1:0] a_vec [softmax_pkg::LANES];
  logic [softmax_pkg::DATA_WIDTH-1:0] o_vec [softmax_pkg::LANES];

  assign a_vec[0] = a_inp0;
  assign a_vec[1] = a_inp1;
  assign a_vec[2] = a_inp2;
  assign a_vec[3] = a_inp3;

  // One subtractor per lane, all sharing the max
  for (genvar i = 0; i < softmax_pkg::LANES; i++) begin : g_sub
    fixed_point_sub u_sub (.a(a_vec[i]), .b(b_inp), .result(o_vec[i]));
  end

  // Lane minus max is never positive
  assign outp0 = o_vec[0];
  assign outp1 = o_vec[1];
  assign outp2 = o_vec[2];
  assign outp3 = o_vec[3];

endmodule

//--- hdl/mode3_exp.sv
`timescale 1ns/1ps

module mode3_exp (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              exp_en,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] diff_lane0,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] diff_lane1,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] diff_lane2,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] diff_lane3,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane0,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane1,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane2,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane3
);

  logic [softmax_pkg::DATA_WIDTH-1:0] d_vec [softmax_pkg::LANES];
  logic [softmax_pkg::EXP_WIDTH-1:0]  e_q   [softmax_pkg::LANES];

  // 2^d for d <= 0 in Q8.8, result in Q1.15
  // 2^f approximated as 1 + f/256 on the fraction
  function automatic logic [softmax_pkg::EXP_WIDTH-1:0] exp2_q15(
    input logic [softmax_pkg::DATA_WIDTH-1:0] d
  );
    logic [8:0]                        n;    // Right shift, 0 to 128
    logic [softmax_pkg::EXP_WIDTH-1:0] mant; // 1.f in Q1.15
    n    = d[15] ? 9'd0 - {d[15], d[15:8]} : 9'd0; // -floor(d/256)
    mant = {1'b1, d[7:0], 7'b0};                   // 0x8000 + f*128
    if (d == softmax_pkg::SAT_MIN || n >= 9'd16) begin
      exp2_q15 = '0; // Underflows Q1.15
    end else begin
      exp2_q15 = mant >> n[3:0];
    end
  endfunction

  assign d_vec[0] = diff_lane0;
  assign d_vec[1] = diff_lane1;
  assign d_vec[2] = diff_lane2;
  assign d_vec[3] = diff_lane3;

  for (genvar i = 0; i < softmax_pkg::LANES; i++) begin : g_exp
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) e_q[i] <= '0;
      else if (exp_en) e_q[i] <= exp2_q15(d_vec[i]); // Buffer data valid
    end
  end

  assign exp_lane0 = e_q[0];
  assign exp_lane1 = e_q[1];
  assign exp_lane2 = e_q[2];
  assign exp_lane3 = e_q[3];

endmodule

//--- hdl/mode4_sum.sv
`timescale 1ns/1ps

module mode4_sum (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              sum_clr,
  input  logic                              sum_en,
  input  logic [softmax_pkg::EXP_WIDTH-1:0] exp_lane0,
  input  logic [softmax_pkg::EXP_WIDTH-1:0] exp_lane1,
  input  logic [softmax_pkg::EXP_WIDTH-1:0] exp_lane2,
  input  logic [softmax_pkg::EXP_WIDTH-1:0] exp_lane3,
  output logic [softmax_pkg::SUM_WIDTH-1:0] sum
);

  localparam int EW = softmax_pkg::EXP_WIDTH;

  logic [EW-1:0] e_vec [softmax_pkg::LANES];
  logic [EW:0]   sum01;    // First tree level
  logic [EW:0]   sum23;
  logic [EW+1:0] beat_sum; // All four lanes
  logic [softmax_pkg::SUM_WIDTH-1:0] acc_q;

  assign e_vec[0] = exp_lane0;
  assign e_vec[1] = exp_lane1;
  assign e_vec[2] = exp_lane2;
  assign e_vec[3] = exp_lane3;

  // Adder tree with one growth bit per level
  assign sum01    = {1'b0, e_vec[0]} + {1'b0, e_vec[1]};
  assign sum23    = {1'b0, e_vec[2]} + {1'b0, e_vec[3]};
  assign beat_sum = {1'b0, sum01} + {1'b0, sum23};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_q <= '0;
    end else if (sum_clr) begin
      acc_q <= '0; // Start of read pass
    end else if (sum_en) begin
      acc_q <= acc_q + softmax_pkg::SUM_WIDTH'(beat_sum);
    end
  end

  // Stable from done until next sum_clr
  assign sum = acc_q;

endmodule

//--- hdl/softmax_ctrl.sv
`timescale 1ns/1ps

module softmax_ctrl #(
  parameter int NUM_WORDS = 32
) (
  input  logic                                             clk,
  input  logic                                             arst_n,
  input  logic                                             in_valid,
  output logic                                             busy,
  output logic                                             wr_en,
  output logic                                             rd_en,
  output logic                                             load_en,
  output logic                                             first_beat,
  output logic                                             exp_en,
  output logic                                             sum_clr,
  output logic                                             sum_en,
  output logic                                             done,
  output logic [$clog2(NUM_WORDS/softmax_pkg::LANES)-1:0] addr,
  output softmax_pkg::ctrl_state_t                         state
);

  localparam int BEATS      = NUM_WORDS / softmax_pkg::LANES; // Beats per vector
  localparam int ADDR_WIDTH = $clog2(BEATS);
  localparam logic [ADDR_WIDTH-1:0] LAST_BEAT = ADDR_WIDTH'(BEATS - 1);

  logic [ADDR_WIDTH-1:0] beat_cnt; // Shared by load and read passes
  logic                  accept;
  logic                  last_beat;

  // Input is taken only while not busy
  assign busy      = (state == softmax_pkg::RUN) || (state == softmax_pkg::FLUSH);
  assign accept    = in_valid & ~busy;
  assign last_beat = (beat_cnt == LAST_BEAT);

  // Load side strobes follow the accepted beat
  assign wr_en      = accept;
  assign load_en    = accept;
  assign first_beat = accept & (state == softmax_pkg::IDLE); // Max gets replaced

  // Read side
  assign rd_en   = (state == softmax_pkg::RUN);
  assign sum_clr = rd_en & (beat_cnt == '0); // First RUN cycle only
  assign addr    = beat_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= softmax_pkg::IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        softmax_pkg::IDLE: begin
          if (accept) begin
            beat_cnt <= beat_cnt + 1'b1; // Beat 0 written this cycle
            state    <= softmax_pkg::LOAD;
          end
        end
        softmax_pkg::LOAD: begin
          if (accept) begin
            if (last_beat) begin
              beat_cnt <= '0; // Read pass restarts at entry 0
              state    <= softmax_pkg::RUN;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        softmax_pkg::RUN: begin
          if (last_beat) begin
            beat_cnt <= '0;
            state    <= softmax_pkg::FLUSH;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        softmax_pkg::FLUSH: begin
          if (done) state <= softmax_pkg::IDLE; // Pipe drained, sum stable
        end
        default: state <= softmax_pkg::IDLE;
      endcase
    end
  end

  // Valid line matching the datapath
  // rd_en -> buffer reg -> exp reg -> accumulator
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_en <= 1'b0;
      sum_en <= 1'b0;
      done   <= 1'b0;
    end else begin
      exp_en <= rd_en;            // Buffer data valid now
      sum_en <= exp_en;           // Exp lanes valid now
      done   <= sum_en & ~exp_en; // Last beat accumulated
    end
  end

endmodule

//--- hdl/softmax_top.sv
`timescale 1ns/1ps

module softmax_top #(
  parameter int NUM_WORDS = 32 // Multiple of 4, 8 to 64
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              in_valid,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane0,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane1,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane2,
  input  logic [softmax_pkg::DATA_WIDTH-1:0] in_lane3,
  output logic                              busy,
  output logic                              out_valid,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane0,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane1,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane2,
  output logic [softmax_pkg::EXP_WIDTH-1:0]  exp_lane3,
  output logic [softmax_pkg::SUM_WIDTH-1:0]  sum,
  output logic                              done,
  output softmax_pkg::ctrl_state_t           state // Debug only
);

  localparam int ADDR_WIDTH = $clog2(NUM_WORDS / softmax_pkg::LANES);

  logic                  wr_en;
  logic                  rd_en;
  logic                  load_en;
  logic                  first_beat;
  logic                  exp_en;
  logic                  sum_clr;
  logic [ADDR_WIDTH-1:0] addr; // Beat index, shared by both passes
  logic [softmax_pkg::DATA_WIDTH-1:0] max_val;
  logic [softmax_pkg::DATA_WIDTH-1:0] rd_lane0, rd_lane1, rd_lane2, rd_lane3;
  logic [softmax_pkg::DATA_WIDTH-1:0] diff0, diff1, diff2, diff3;

  // out_valid is the accumulate strobe
  softmax_ctrl #(.NUM_WORDS(NUM_WORDS)) u_ctrl (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
    .busy(busy), .wr_en(wr_en), .rd_en(rd_en),
    .load_en(load_en), .first_beat(first_beat), .exp_en(exp_en),
    .sum_clr(sum_clr), .sum_en(out_valid), .done(done),
    .addr(addr), .state(state)
  );

  vec_buffer #(.NUM_WORDS(NUM_WORDS)) u_buf (
    .clk(clk), .wr_en(wr_en), .rd_en(rd_en), .addr(addr),
    .wr_lane0(in_lane0), .wr_lane1(in_lane1), .wr_lane2(in_lane2), .wr_lane3(in_lane3),
    .rd_lane0(rd_lane0), .rd_lane1(rd_lane1), .rd_lane2(rd_lane2), .rd_lane3(rd_lane3)
  );

  // Max follows the raw input during load
  mode1_max u_max (
    .clk(clk), .arst_n(arst_n), .load_en(load_en), .first_beat(first_beat),
    .in_lane0(in_lane0), .in_lane1(in_lane1), .in_lane2(in_lane2), .in_lane3(in_lane3),
    .max_val(max_val)
  );

  mode2_sub u_sub (
    .a_inp0(rd_lane0), .a_inp1(rd_lane1), .a_inp2(rd_lane2), .a_inp3(rd_lane3),
    .b_inp(max_val),
    .outp0(diff0), .outp1(diff1), .outp2(diff2), .outp3(diff3)
  );

  mode3_exp u_exp (
    .clk(clk), .arst_n(arst_n), .exp_en(exp_en),
    .diff_lane0(diff0), .diff_lane1(diff1), .diff_lane2(diff2), .diff_lane3(diff3),
    .exp_lane0(exp_lane0), .exp_lane1(exp_lane1),
    .exp_lane2(exp_lane2), .exp_lane3(exp_lane3)
  );

  mode4_sum u_sum (
    .clk(clk), .arst_n(arst_n), .sum_clr(sum_clr), .sum_en(out_valid),
    .exp_lane0(exp_lane0), .exp_lane1(exp_lane1),
    .exp_lane2(exp_lane2), .exp_lane3(exp_lane3),
    .sum(sum)
  );

endmodule

//--- hdl/vec_buffer.sv
`timescale 1ns/1ps

module vec_buffer #(
  parameter int NUM_WORDS = 32
) (
  input  logic                                             clk,
  input  logic                                             wr_en,
  input  logic                                             rd_en,
  input  logic [$clog2(NUM_WORDS/softmax_pkg::LANES)-1:0] addr,
  input  logic [softmax_pkg::DATA_WIDTH-1:0]               wr_lane0,
  input  logic [softmax_pkg::DATA_WIDTH-1:0]               wr_lane1,
  input  logic [softmax_pkg::DATA_WIDTH-1:0]               wr_lane2,
  input  logic [softmax_pkg::DATA_WIDTH-1:0]               wr_lane3,
  output logic [softmax_pkg::DATA_WIDTH-1:0]               rd_lane0,
  output logic [softmax_pkg::DATA_WIDTH-1:0]               rd_lane1,
  output logic [softmax_pkg::DATA_WIDTH-1:0]               rd_lane2,
  output logic [softmax_pkg::DATA_WIDTH-1:0]               rd_lane3
);

  localparam int DEPTH   = NUM_WORDS / softmax_pkg::LANES; // One entry per beat
  localparam int ENTRY_W = softmax_pkg::LANES * softmax_pkg::DATA_WIDTH;
  localparam int DW      = softmax_pkg::DATA_WIDTH;

  logic [ENTRY_W-1:0] mem [DEPTH]; // Four words per location
  logic [ENTRY_W-1:0] rd_q;

  always_ff @(posedge clk) begin
    if (wr_en) mem[addr] <= {wr_lane3, wr_lane2, wr_lane1, wr_lane0};
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    if (rd_en) rd_q <= mem[addr];
  end

  // Lane 0 in the low word
  assign rd_lane0 = rd_q[0*DW +: DW];
  assign rd_lane1 = rd_q[1*DW +: DW];
  assign rd_lane2 = rd_q[2*DW +: DW];
  assign rd_lane3 = rd_q[3*DW +: DW];

endmodule

//--- softmax_top.f
common/softmax_pkg.sv
hdl/softmax_ctrl.sv
hdl/vec_buffer.sv
hdl/mode1_max.sv
hdl/mode2_sub.sv
hdl/mode3_exp.sv
hdl/mode4_sum.sv
hdl/softmax_top.sv
testbench/softmax_tb.sv

//--- testbench/softmax_tb.sv
`timescale 1ns/1ps

module softmax_tb;

  localparam int NUM_WORDS   = 32;
  localparam int LANES       = softmax_pkg::LANES;
  localparam int BEATS       = NUM_WORDS / LANES; // Beats per vector
  localparam int DW          = softmax_pkg::DATA_WIDTH;
  localparam int EW          = softmax_pkg::EXP_WIDTH;
  localparam int TIMEOUT     = 200; // Cycles allowed per wait loop
  localparam int NUM_VECTORS = 6;

  // Stimulus kinds
  localparam int NARROW_RANDOM = 0;
  localparam int FULL_RANDOM   = 1;
  localparam int MAX_LATE      = 2;
  localparam int ALL_EQUAL     = 3;
  localparam int SATURATE      = 4;

  logic                              clk;
  logic                              arst_n;
  logic                              in_valid;
  logic [DW-1:0]                     in_lane0, in_lane1, in_lane2, in_lane3;
  logic                              busy;
  logic                              out_valid;
  logic [EW-1:0]                     exp_lane0, exp_lane1, exp_lane2, exp_lane3;
  logic [softmax_pkg::SUM_WIDTH-1:0] sum;
  logic                              done;
  softmax_pkg::ctrl_state_t          state;

  logic [DW-1:0] vec_words [NUM_WORDS]; // Vector under test
  logic [EW-1:0] exp_ref   [NUM_WORDS]; // Expected exponentials
  logic [EW-1:0] exp_out   [LANES];
  logic [EW-1:0] exp_q     [$];         // Lanes still to come out
  logic [31:0]   sum_q     [$];
  string         name_q    [$];

  int cyc;
  int last_beat_cyc; // Cycle of the last accepted load beat
  int beat_cnt;
  int done_count;
  int check_count;
  int mismatch_count;
  int fail_count;
  bit timed_out;

  softmax_top #(.NUM_WORDS(NUM_WORDS)) UUT (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
    .in_lane0(in_lane0), .in_lane1(in_lane1), .in_lane2(in_lane2), .in_lane3(in_lane3),
    .busy(busy), .out_valid(out_valid),
    .exp_lane0(exp_lane0), .exp_lane1(exp_lane1), .exp_lane2(exp_lane2), .exp_lane3(exp_lane3),
    .sum(sum), .done(done), .state(state)
  );

  assign exp_out[0] = exp_lane0;
  assign exp_out[1] = exp_lane1;
  assign exp_out[2] = exp_lane2;
  assign exp_out[3] = exp_lane3;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      mismatch_count++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Max, saturating differences, 2^d in Q1.15 and their sum for the stored vector
  function automatic logic [31:0] build_reference();
    int          i;
    int          mx;
    int          d;
    int          n;
    int          e;
    logic [31:0] total;
    mx    = int'($signed(vec_words[0]));
    total = '0;
    for (i = 1; i < NUM_WORDS; i++) begin
      if (int'($signed(vec_words[i])) > mx) mx = int'($signed(vec_words[i]));
    end
    for (i = 0; i < NUM_WORDS; i++) begin
      d = int'($signed(vec_words[i])) - mx; // Never positive
      if (d < -32768) d = -32768;           // Clamp to most negative Q8.8
      n = -(d >>> 8);                       // -floor(d/256)
      e = (n >= 16) ? 0 : (32768 + (d & 255) * 128) >> n;
      exp_ref[i] = EW'(e);
      total += e;
    end
    return total;
  endfunction

  task automatic fill_vector(input int kind);
    int i;
    for (i = 0; i < NUM_WORDS; i++) begin
      case (kind)
        NARROW_RANDOM: vec_words[i] = DW'(int'($urandom % 2048) - 1024); // +-4.0
        FULL_RANDOM:   vec_words[i] = DW'($urandom);
        MAX_LATE:      vec_words[i] = DW'(-int'($urandom % 1024) - 256); // All below -1.0
        ALL_EQUAL:     vec_words[i] = 16'h0123;
        default: begin
          case (i % 4)
            0:       vec_words[i] = 16'h7FFF;
            1:       vec_words[i] = 16'h8000; // Difference saturates
            2:       vec_words[i] = 16'h8001;
            default: vec_words[i] = 16'h7E80; // Small shift with nonzero result
          endcase
        end
      endcase
    end
    if (kind == MAX_LATE) begin
      vec_words[NUM_WORDS-3] = 16'h0300; // Two lanes of the last beat hold the max
      vec_words[NUM_WORDS-1] = 16'h0300;
    end
  endtask

  // Loads one vector and pulses junk while busy until done
  task automatic run_vector(input string name, input int kind, input bit gaps,
                            input bit uniform);
    int          b;
    int          i;
    bit          ready;
    logic [31:0] total;
    if (timed_out) return;
    fill_vector(kind);
    total = build_reference();
    for (i = 0; i < NUM_WORDS; i++) exp_q.push_back(exp_ref[i]);
    sum_q.push_back(total);
    name_q.push_back(name);
    ready = 1'b0;
    for (i = 0; i < TIMEOUT && !ready; i++) begin
      @(negedge clk);
      ready = !busy;
    end
    if (!ready) begin
      fail_count++;
      timed_out = 1'b1;
      $display("Error: %s timed out waiting for busy to drop", name);
      return;
    end
    for (b = 0; b < BEATS; b++) begin
      if (gaps && ($urandom % 4 == 0)) begin
        in_valid = 1'b0; // Idle cycle inside load
        @(negedge clk);
      end
      in_valid = 1'b1;
      in_lane0 = vec_words[b*LANES];
      in_lane1 = vec_words[b*LANES+1];
      in_lane2 = vec_words[b*LANES+2];
      in_lane3 = vec_words[b*LANES+3];
      if (b == BEATS - 1) last_beat_cyc = cyc;
      @(negedge clk);
    end
    for (i = 0; i < TIMEOUT; i++) begin
      if (done) break;
      check_value($sformatf("%s busy", name), 1, busy); // High from RUN until done
      in_valid = 1'($urandom); // Must be ignored
      in_lane0 = DW'($urandom);
      in_lane1 = DW'($urandom);
      in_lane2 = DW'($urandom);
      in_lane3 = DW'($urandom);
      @(negedge clk);
    end
    in_valid = 1'b0;
    if (!done) begin
      fail_count++;
      timed_out = 1'b1;
      $display("Error: %s timed out waiting for done", name);
      return;
    end
    if (uniform) check_value($sformatf("%s uniform sum", name), NUM_WORDS * 32'h8000, 32'(sum));
  endtask

  // Pops one expected beat per out_valid and checks the sum on done
  always @(negedge clk) begin : monitor
    int l;
    if (arst_n) begin
      if (out_valid) begin
        if (exp_q.size() < LANES || name_q.size() == 0) begin
          fail_count++;
          $display("Error: out_valid at cycle %0d with no beat expected", cyc);
        end else begin
          for (l = 0; l < LANES; l++) begin
            check_value($sformatf("%s beat %0d lane %0d", name_q[0], beat_cnt, l),
                        exp_q.pop_front(), exp_out[l]);
          end
        end
        beat_cnt++;
      end
      if (done) begin
        if (sum_q.size() == 0 || name_q.size() == 0) begin
          fail_count++;
          $display("Error: done at cycle %0d with no vector expected", cyc);
        end else begin
          check_value($sformatf("%s sum", name_q[0]), sum_q.pop_front(), 32'(sum));
          check_value($sformatf("%s beat count", name_q[0]), BEATS, beat_cnt);
          check_value($sformatf("%s done latency", name_q[0]), BEATS + 3,
                      cyc - last_beat_cyc);
          void'(name_q.pop_front());
        end
        beat_cnt = 0;
        done_count++;
      end
    end
  end

  initial begin
    void'($urandom(19930));
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_lane0 = '0;
    in_lane1 = '0;
    in_lane2 = '0;
    in_lane3 = '0;
    repeat (3) @(negedge clk);
    check_value("reset busy", 0, busy);
    check_value("reset out_valid", 0, out_valid);
    check_value("reset done", 0, done);
    check_value("reset state", softmax_pkg::IDLE, state);
    check_value("reset sum", 0, 32'(sum));
    arst_n = 1'b1;
    // Vectors run back to back
    run_vector("random_narrow", NARROW_RANDOM, 1'b1, 1'b0);
    run_vector("random_full", FULL_RANDOM, 1'b0, 1'b0);
    run_vector("max_late", MAX_LATE, 1'b0, 1'b0);
    run_vector("all_equal", ALL_EQUAL, 1'b1, 1'b1);
    run_vector("saturation", SATURATE, 1'b0, 1'b0);
    run_vector("random_gaps", NARROW_RANDOM, 1'b1, 1'b0);
    repeat (2) @(negedge clk);
    check_value("vectors completed", NUM_VECTORS, done_count);
    if (exp_q.size() != 0) begin
      fail_count++;
      $display("Error: %0d expected exponential lanes never came out", exp_q.size());
    end
    $display("Checks %0d, mismatches %0d, other failures %0d",
             check_count, mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
